// File: Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_input_layer
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: input_layer_pkg.sv
// input layer reader shared definitions
// beat, id, window and AXI read channel types used across the datapath

package input_layer_pkg;

	// ------------------------------------------------------------------
	// geometry of the fetch and the window
	// ------------------------------------------------------------------
	localparam int BEAT_BYTES    = 8;
	localparam int WORDS_PER_ROW = 8;
	localparam int WIN_SIZE      = 3;
	localparam int BURST_BEATS   = 24;
	localparam int ROW_SHIFT     = 6;
	localparam int LAYER_SHIFT   = 12;

	// arsize and arburst encodings
	localparam logic [2:0] AXI_SIZE_8B    = 3'd3;
	localparam logic [1:0] AXI_BURST_INCR = 2'd1;

	typedef logic [9:0] id_t;
	typedef logic [BEAT_BYTES*8-1:0] beat_t;

	typedef struct packed {
		id_t num_layers;
		id_t num_rows;
		id_t num_cols;
	} layer_cfg_t;

	// ------------------------------------------------------------------
	// read address and read data channels
	// ------------------------------------------------------------------
	typedef struct packed {
		logic [7:0] arlen;
		logic [2:0] arsize;
		logic [1:0] arburst;
		logic       arvalid;
	} axi_ar_t;

	typedef struct packed {
		beat_t rdata;
		logic  rlast;
		logic  rvalid;
	} axi_r_t;

	// one row buffer write, lane is the image row inside the burst
	typedef struct packed {
		logic       en;
		logic       bank;
		logic [1:0] lane;
		logic [2:0] word;
		beat_t      data;
	} buf_wr_t;

	typedef struct packed {
		id_t layer;
		id_t row;
		id_t col;
	} win_pos_t;

	// row 0 sits in the top bits, leftmost byte of each row highest
	typedef union packed {
		logic [WIN_SIZE*WIN_SIZE*8-1:0]                 flat;
		logic [0:WIN_SIZE-1][0:WIN_SIZE-1][7:0]         rows;
	} window_t;

endpackage

// File: input_layer_top.sv
// input layer reader top level
// AXI4 read master fetching three feature map rows per (row, layer),
// a double-banked row buffer, and a 3x3 window streamer

module input_layer_top #(
	parameter int ADDR_W = 32
) (
	input  logic                          clk,
	input  logic                          reset_n,
	// AXI read address channel
	output logic [ADDR_W-1:0]             araddr,
	output input_layer_pkg::axi_ar_t      ar,
	input  logic                          arready,
	// AXI read data channel
	input  input_layer_pkg::axi_r_t       r,
	output logic                          rready,
	// layer configuration, held stable outside reset
	input  logic [ADDR_W-1:0]             base_addr,
	input  input_layer_pkg::layer_cfg_t   cfg,
	input  logic                          ddr3_data_rdy,
	// window stream
	output input_layer_pkg::window_t      win_data,
	output logic                          win_valid,
	output input_layer_pkg::win_pos_t     win_pos,
	input  logic                          win_ready
);
	import input_layer_pkg::*;

	buf_wr_t    wr;
	logic [1:0] bank_full;
	logic       bank_release;
	logic       rd_bank;
	logic [2:0] rd_word;
	beat_t      rd_data [WIN_SIZE];

	// burst sequencing and buffer write steering
	row_fetch_engine #(
		.ADDR_W (ADDR_W)
	) u_row_fetch_engine (
		.clk           (clk),
		.reset_n       (reset_n),
		.ddr3_data_rdy (ddr3_data_rdy),
		.base_addr     (base_addr),
		.cfg           (cfg),
		.arready       (arready),
		.r             (r),
		.bank_release  (bank_release),
		.araddr        (araddr),
		.ar            (ar),
		.rready        (rready),
		.wr            (wr),
		.bank_full     (bank_full)
	);

	row_bank_ram u_row_bank_ram (
		.clk     (clk),
		.wr      (wr),
		.rd_bank (rd_bank),
		.rd_word (rd_word),
		.rd_data (rd_data)
	);

	window_streamer u_window_streamer (
		.clk          (clk),
		.reset_n      (reset_n),
		.cfg          (cfg),
		.bank_full    (bank_full),
		.rd_data      (rd_data),
		.win_ready    (win_ready),
		.rd_bank      (rd_bank),
		.rd_word      (rd_word),
		.bank_release (bank_release),
		.win_data     (win_data),
		.win_valid    (win_valid),
		.win_pos      (win_pos)
	);

endmodule

// File: project.f
input_layer_pkg.sv
row_bank_ram.sv
row_fetch_engine.sv
window_streamer.sv
input_layer_top.sv
tb_input_layer_sva.sv
tb_input_layer.sv

// File: row_bank_ram.sv
// double-banked row buffer
// three lanes of 2 banks x 8 words, one write port, registered read of all lanes

module row_bank_ram (
	input  logic                        clk,
	input  input_layer_pkg::buf_wr_t    wr,
	input  logic                        rd_bank,
	input  logic [2:0]                  rd_word,
	output input_layer_pkg::beat_t      rd_data [input_layer_pkg::WIN_SIZE]
);
	import input_layer_pkg::*;

	// one memory per lane, addressed by {bank, word}
	for (genvar i = 0; i < WIN_SIZE; i++) begin : g_lane
		beat_t mem [2*WORDS_PER_ROW];

		always_ff @(posedge clk) begin
			if (wr.en && (wr.lane == 2'(i)))
				mem[{wr.bank, wr.word}] <= wr.data;
		end

		// one cycle of read latency
		always_ff @(posedge clk) begin
			rd_data[i] <= mem[{rd_bank, rd_word}];
		end
	end

endmodule

// File: row_fetch_engine.sv
// row fetch engine
// issues one 24-beat incrementing burst per (row, layer) position,
// steers each beat into the row buffer and tracks which bank is full

module row_fetch_engine #(
	parameter int ADDR_W = 32
) (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          ddr3_data_rdy,
	input  logic [ADDR_W-1:0]             base_addr,
	input  input_layer_pkg::layer_cfg_t   cfg,
	input  logic                          arready,
	input  input_layer_pkg::axi_r_t       r,
	input  logic                          bank_release,
	output logic [ADDR_W-1:0]             araddr,
	output input_layer_pkg::axi_ar_t      ar,
	output logic                          rready,
	output input_layer_pkg::buf_wr_t      wr,
	output logic [1:0]                    bank_full
);
	import input_layer_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ADDR,
		S_DATA
	} fetch_state_t;

	fetch_state_t state;
	id_t          f_layer;
	id_t          f_row;
	logic [4:0]   beat_cnt;
	logic         wr_bank;
	logic         rel_bank;
	logic         beat_acc;
	logic         last_acc;

	assign beat_acc = r.rvalid & rready;
	assign last_acc = beat_acc & r.rlast;

	// ------------------------------------------------------------------
	// read address channel
	// ------------------------------------------------------------------
	// layers are 4 KB apart, rows 64 bytes apart
	assign araddr = base_addr
		+ (ADDR_W'(f_layer) << LAYER_SHIFT)
		+ (ADDR_W'(f_row) << ROW_SHIFT);

	always_comb begin
		ar.arlen   = 8'(BURST_BEATS - 1);
		ar.arsize  = AXI_SIZE_8B;
		ar.arburst = AXI_BURST_INCR;
		ar.arvalid = (state == S_ADDR);
	end

	// rready covers the whole data phase of the burst
	assign rready = (state == S_DATA);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				// only fill a bank the streamer has given back
				S_IDLE: if (ddr3_data_rdy && !bank_full[wr_bank]) state <= S_ADDR;
				S_ADDR: if (arready) state <= S_DATA;
				S_DATA: if (last_acc) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// fetch position, layer first then row
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			f_layer <= '0;
			f_row   <= '0;
		end else if (last_acc) begin
			if (f_layer == cfg.num_layers - 1'b1) begin
				f_layer <= '0;
				// wrap after the last row so passes repeat
				if (f_row == cfg.num_rows - 1'b1)
					f_row <= '0;
				else
					f_row <= f_row + 1'b1;
			end else begin
				f_layer <= f_layer + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// beat steering and bank bookkeeping
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n)
			beat_cnt <= '0;
		else if (last_acc)
			beat_cnt <= '0;
		else if (beat_acc)
			beat_cnt <= beat_cnt + 1'b1;
	end

	// beat k lands in lane k/8, word k mod 8
	always_comb begin
		wr.en   = beat_acc;
		wr.bank = wr_bank;
		wr.lane = 2'(beat_cnt / WORDS_PER_ROW);
		wr.word = 3'(beat_cnt % WORDS_PER_ROW);
		wr.data = r.rdata;
	end

	// rel_bank mirrors the streamer's read bank
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			bank_full <= '0;
			wr_bank   <= 1'b0;
			rel_bank  <= 1'b0;
		end else begin
			if (last_acc) begin
				bank_full[wr_bank] <= 1'b1;
				wr_bank            <= ~wr_bank;
			end
			if (bank_release) begin
				bank_full[rel_bank] <= 1'b0;
				rel_bank            <= ~rel_bank;
			end
		end
	end

endmodule

// File: tb_input_layer.sv
// testbench for the input layer reader
// AXI read slave model with a byte rule memory, directed tests that check
// every 3x3 window and its ids against a reference built from the memory rule

module tb_input_layer;
	import input_layer_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int WIN_WAIT    = 2000;
	// windows over all directed tests, sizes the watchdog
	localparam int TOTAL_WINDOWS = 1*2*4 + 3*2*5 + 2*2*10 + 2*3*62;

	logic        clk;
	logic        reset_n;
	logic [31:0] araddr;
	axi_ar_t     ar;
	logic        arready = 1'b0;
	axi_r_t      r = '0;
	logic        rready;
	logic [31:0] base_addr;
	layer_cfg_t  cfg;
	logic        ddr3_data_rdy;
	window_t     win_data;
	logic        win_valid;
	win_pos_t    win_pos;
	logic        win_ready = 1'b0;

	integer seed = 32'h1bcb_b844;
	logic   slow_slave;
	logic   rnd_ready;
	int     n_checks;
	int     n_errors;

	// slave model state, handshakes sampled at the falling edge
	logic        rst_low = 1'b1;
	logic        ar_hs = 1'b0;
	logic        r_hs = 1'b0;
	logic [31:0] ar_addr_s = '0;
	logic        burst_on = 1'b0;
	int          beat = 0;
	logic [31:0] burst_addr = '0;
	logic [31:0] ar_addr_q [$];
	axi_ar_t     ar_q [$];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	input_layer_top #(
		.ADDR_W (32)
	) u_input_layer_top (
		.clk           (clk),
		.reset_n       (reset_n),
		.araddr        (araddr),
		.ar            (ar),
		.arready       (arready),
		.r             (r),
		.rready        (rready),
		.base_addr     (base_addr),
		.cfg           (cfg),
		.ddr3_data_rdy (ddr3_data_rdy),
		.win_data      (win_data),
		.win_valid     (win_valid),
		.win_pos       (win_pos),
		.win_ready     (win_ready)
	);

	// ------------------------------------------------------------------
	// memory rule and reference windows
	// ------------------------------------------------------------------
	// byte at a is a[7:0] xor a[19:12]
	function automatic logic [7:0] byte_at(input logic [31:0] a);
		return a[7:0] ^ a[19:12];
	endfunction

	// byte i of a beat sits at bits 8i+7:8i
	function automatic beat_t beat_at(input logic [31:0] a);
		beat_t d;
		for (int i = 0; i < 8; i++)
			d[8*i +: 8] = byte_at(a + i);
		return d;
	endfunction

	// row k from top bits down, leftmost byte highest
	function automatic logic [71:0] ref_window(input logic [31:0] base, input int lay,
			input int row, input int col);
		logic [71:0] w;
		w = '0;
		for (int k = 0; k < 3; k++) begin
			for (int j = 0; j < 3; j++)
				w = {w[63:0], byte_at(base + (lay << 12) + ((row + k) << 6) + (col + j))};
		end
		return w;
	endfunction

	// ------------------------------------------------------------------
	// AXI slave model and window ready
	// ------------------------------------------------------------------
	always @(negedge clk) begin
		rst_low   = !reset_n;
		ar_hs     = ar.arvalid && arready;
		r_hs      = r.rvalid && rready;
		ar_addr_s = araddr;
		if (ar_hs && reset_n) begin
			ar_addr_q.push_back(araddr);
			ar_q.push_back(ar);
		end
	end

	always @(posedge clk) begin
		#DRIVE_DELAY;
		win_ready = !rnd_ready || (($random(seed) & 1) != 0);
		if (rst_low) begin
			arready  = 1'b0;
			r        = '0;
			burst_on = 1'b0;
			beat     = 0;
		end else begin
			if (r_hs) begin
				beat++;
				if (beat == 24)
					burst_on = 1'b0;
			end
			if (ar_hs) begin
				burst_addr = ar_addr_s;
				burst_on   = 1'b1;
				beat       = 0;
				arready    = 1'b0;
			end else if (ar.arvalid && !burst_on) begin
				// random accept delay on a slow slave
				arready = !slow_slave || (($random(seed) & 3) == 0);
			end
			if (burst_on && !(r.rvalid && !r_hs)) begin
				r.rvalid = !slow_slave || (($random(seed) & 3) != 0);
				r.rdata  = beat_at(burst_addr + beat * 8);
				r.rlast  = (beat == 23);
			end else if (!burst_on) begin
				r = '0;
			end
		end
	end

	// ------------------------------------------------------------------
	// checking and run control
	// ------------------------------------------------------------------
	task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at time %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#DRIVE_DELAY;
	endtask

	// new configuration only across a reset
	task automatic start_layer(input int layers, input int rows, input int cols,
			input logic [31:0] base);
		@(posedge clk);
		#DRIVE_DELAY;
		reset_n       = 1'b0;
		ddr3_data_rdy = 1'b0;
		cfg           = '{num_layers: 10'(layers), num_rows: 10'(rows), num_cols: 10'(cols)};
		base_addr     = base;
		ar_addr_q.delete();
		ar_q.delete();
		wait_cycles(4);
		reset_n = 1'b1;
	endtask

	task automatic next_window(output logic ok);
		int waited;
		waited = 0;
		ok     = 1'b0;
		while (!ok && waited < WIN_WAIT) begin
			@(negedge clk);
			ok = win_valid && win_ready;
			waited++;
		end
	endtask

	// one full pass, row then layer then column
	task automatic stream_pass(input int layers, input int rows, input int cols,
			input string name);
		logic ok;
		ddr3_data_rdy = 1'b1;
		for (int ri = 0; ri < rows; ri++) begin
			for (int li = 0; li < layers; li++) begin
				for (int ci = 0; ci < cols; ci++) begin
					next_window(ok);
					if (!ok) begin
						n_errors++;
						$display("%s: no window handshake within %0d cycles at layer %0d row %0d col %0d",
							name, WIN_WAIT, li, ri, ci);
						return;
					end
					check(128'(win_data.flat), 128'(ref_window(base_addr, li, ri, ci)),
						$sformatf("%s window data l%0d r%0d c%0d", name, li, ri, ci));
					check(128'(win_pos), 128'({10'(li), 10'(ri), 10'(ci)}),
						$sformatf("%s window id l%0d r%0d c%0d", name, li, ri, ci));
				end
			end
		end
		wait_cycles(1);
		ddr3_data_rdy = 1'b0;
	endtask

	// bursts in row then layer order, 24 beats of 8 bytes, incrementing
	task automatic check_ar_log(input int layers, input int rows, input string name);
		int idx;
		if (ar_addr_q.size() < layers * rows) begin
			n_errors++;
			$display("%s: only %0d read bursts seen, expected at least %0d",
				name, ar_addr_q.size(), layers * rows);
		end else begin
			for (int ri = 0; ri < rows; ri++) begin
				for (int li = 0; li < layers; li++) begin
					idx = ri * layers + li;
					check(128'(ar_addr_q[idx]), 128'(base_addr + (li << 12) + (ri << 6)),
						$sformatf("%s araddr of burst %0d", name, idx));
					check(128'(ar_q[idx].arlen), 128'(23), $sformatf("%s arlen", name));
					check(128'(ar_q[idx].arsize), 128'(3), $sformatf("%s arsize", name));
					check(128'(ar_q[idx].arburst), 128'(1), $sformatf("%s arburst", name));
				end
			end
		end
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------
	task automatic test_reset_idle();
		start_layer(1, 2, 4, 32'h0001_0000);
		@(negedge clk);
		check(128'(ar.arvalid), 128'(0), "arvalid after reset");
		check(128'(rready), 128'(0), "rready after reset");
		check(128'(win_valid), 128'(0), "win_valid after reset");
		repeat (20) begin
			@(negedge clk);
			check(128'(ar.arvalid), 128'(0), "arvalid with ddr3_data_rdy low");
		end
	endtask

	task automatic test_single_layer();
		slow_slave = 1'b0;
		rnd_ready  = 1'b0;
		start_layer(1, 2, 4, 32'h0002_3000);
		stream_pass(1, 2, 4, "single layer");
	endtask

	task automatic test_multi_layer();
		start_layer(3, 2, 5, 32'h0004_8000);
		stream_pass(3, 2, 5, "multi layer");
		check_ar_log(3, 2, "multi layer");
	endtask

	task automatic test_backpressure();
		rnd_ready = 1'b1;
		start_layer(2, 2, 10, 32'h0007_1000);
		stream_pass(2, 2, 10, "back-pressure");
		rnd_ready = 1'b0;
	endtask

	// random arready delays and rvalid gaps, widest rows
	task automatic test_slow_slave();
		slow_slave = 1'b1;
		start_layer(2, 3, 62, 32'h000a_c000);
		stream_pass(2, 3, 62, "slow slave");
		check_ar_log(2, 3, "slow slave");
		slow_slave = 1'b0;
	endtask

	initial begin
		reset_n       = 1'b0;
		ddr3_data_rdy = 1'b0;
		base_addr     = '0;
		cfg           = '0;
		slow_slave    = 1'b0;
		rnd_ready     = 1'b0;
		n_checks      = 0;
		n_errors      = 0;
		test_reset_idle();
		test_single_layer();
		test_multi_layer();
		test_backpressure();
		test_slow_slave();
		finish_run();
	end

	// watchdog, 200 cycles per expected window
	initial begin
		#(TOTAL_WINDOWS * 200 * CLK_PERIOD);
		n_errors++;
		$display("timeout: the tests did not finish within %0d clock cycles",
			TOTAL_WINDOWS * 200);
		finish_run();
	end

endmodule

// File: tb_input_layer_sva.sv
// handshake assertions for the input layer reader
// bound to the top level, covers AR hold, window hold and R channel idle

module tb_input_layer_sva #(
	parameter int ADDR_W = 32
) (
	input logic                          clk,
	input logic                          reset_n,
	input logic [ADDR_W-1:0]             araddr,
	input input_layer_pkg::axi_ar_t      ar,
	input logic                          arready,
	input input_layer_pkg::axi_r_t       r,
	input logic                          rready,
	input input_layer_pkg::window_t      win_data,
	input logic                          win_valid,
	input input_layer_pkg::win_pos_t     win_pos,
	input logic                          win_ready
);
	// burst open from AR acceptance to the accepted rlast beat
	logic in_burst;

	always_ff @(posedge clk) begin
		if (!reset_n)
			in_burst <= 1'b0;
		else if (ar.arvalid && arready)
			in_burst <= 1'b1;
		else if (r.rvalid && rready && r.rlast)
			in_burst <= 1'b0;
	end

	a_ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
		ar.arvalid && !arready |=> ar.arvalid && $stable(araddr))
		else $error("arvalid or araddr changed before arready");

	a_win_hold: assert property (@(posedge clk) disable iff (!reset_n)
		win_valid && !win_ready |=> win_valid && $stable(win_data) && $stable(win_pos))
		else $error("window changed while stalled");

	a_rready_idle: assert property (@(posedge clk) disable iff (!reset_n)
		!in_burst |-> !rready)
		else $error("rready high outside a burst");

endmodule

bind input_layer_top tb_input_layer_sva #(
	.ADDR_W (ADDR_W)
) u_tb_input_layer_sva (
	.clk       (clk),
	.reset_n   (reset_n),
	.araddr    (araddr),
	.ar        (ar),
	.arready   (arready),
	.r         (r),
	.rready    (rready),
	.win_data  (win_data),
	.win_valid (win_valid),
	.win_pos   (win_pos),
	.win_ready (win_ready)
);

// File: window_streamer.sv
// window streamer
// loads a full bank into three 64-byte row registers, then emits one
// 3x3 byte window per column with its layer, row and column ids

module window_streamer (
	input  logic                          clk,
	input  logic                          reset_n,
	input  input_layer_pkg::layer_cfg_t   cfg,
	input  logic [1:0]                    bank_full,
	input  input_layer_pkg::beat_t        rd_data [input_layer_pkg::WIN_SIZE],
	input  logic                          win_ready,
	output logic                          rd_bank,
	output logic [2:0]                    rd_word,
	output logic                          bank_release,
	output input_layer_pkg::window_t      win_data,
	output logic                          win_valid,
	output input_layer_pkg::win_pos_t     win_pos
);
	import input_layer_pkg::*;

	localparam int BEAT_W = $bits(beat_t);
	localparam int ROW_W  = WORDS_PER_ROW * BEAT_W;

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOAD,
		S_STREAM
	} stream_state_t;

	stream_state_t    state;
	logic [3:0]       ld_cnt;
	logic [2:0]       cap_word;
	logic [ROW_W-1:0] row_q [WIN_SIZE];
	id_t              w_layer;
	id_t              w_row;
	id_t              w_col;
	logic             win_acc;
	logic             last_col;

	assign win_valid = (state == S_STREAM);
	assign win_acc   = win_valid & win_ready;
	assign last_col  = (w_col == cfg.num_cols - 1'b1);

	// ------------------------------------------------------------------
	// load phase
	// ------------------------------------------------------------------
	// read address runs 0..7, data returns one cycle later
	assign rd_word  = ld_cnt[2:0];
	assign cap_word = ld_cnt[2:0] - 3'd1;

	// capture word ld_cnt-1 of every lane into its row register
	always_ff @(posedge clk) begin
		if (state == S_LOAD && ld_cnt != 4'd0) begin
			for (int i = 0; i < WIN_SIZE; i++)
				row_q[i][cap_word*BEAT_W +: BEAT_W] <= rd_data[i];
		end
	end

	// ------------------------------------------------------------------
	// window assembly
	// ------------------------------------------------------------------
	// bytes c, c+1, c+2 of each row, byte b of a row sits at bits 8b+7:8b
	always_comb begin
		for (int k = 0; k < WIN_SIZE; k++) begin
			for (int j = 0; j < WIN_SIZE; j++)
				win_data.rows[k][j] = row_q[k][(int'(w_col[5:0]) + j)*8 +: 8];
		end
	end

	assign win_pos = '{layer: w_layer, row: w_row, col: w_col};

	// ------------------------------------------------------------------
	// control FSM and position counters
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state        <= S_IDLE;
			ld_cnt       <= '0;
			rd_bank      <= 1'b0;
			bank_release <= 1'b0;
			w_layer      <= '0;
			w_row        <= '0;
			w_col        <= '0;
		end else begin
			bank_release <= 1'b0;
			case (state)
				S_IDLE: begin
					if (bank_full[rd_bank]) begin
						state  <= S_LOAD;
						ld_cnt <= '0;
					end
				end
				S_LOAD: begin
					// 8 reads plus one latency cycle
					if (ld_cnt == 4'(WORDS_PER_ROW)) begin
						state  <= S_STREAM;
						ld_cnt <= '0;
					end else begin
						ld_cnt <= ld_cnt + 1'b1;
					end
				end
				S_STREAM: begin
					if (win_acc && last_col) begin
						// bank done, hand it back and move to the other one
						w_col        <= '0;
						bank_release <= 1'b1;
						rd_bank      <= ~rd_bank;
						state        <= S_IDLE;
						if (w_layer == cfg.num_layers - 1'b1) begin
							w_layer <= '0;
							if (w_row == cfg.num_rows - 1'b1)
								w_row <= '0;
							else
								w_row <= w_row + 1'b1;
						end else begin
							w_layer <= w_layer + 1'b1;
						end
					end else if (win_acc) begin
						w_col <= w_col + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule
